//--- hw/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [9:0]  asid_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [36:0] tlb_cmp_t;
    typedef logic [25:0] tlb_trans_t;
    typedef logic [1:0]  fault_t;
    typedef logic [1:0]  mgmt_op_t;
    typedef logic [4:0]  inv_op_t;

    // Compare part field offsets, E ASID G PS VPPN from the top
    localparam int CMP_E    = 36;
    localparam int CMP_ASID = 26;
    localparam int CMP_G    = 25;
    localparam int CMP_PS   = 19;
    localparam int CMP_VPPN = 0;

    // Translation part field offsets, V D MAT PLV PPN from the top
    localparam int TRANS_V   = 25;
    localparam int TRANS_D   = 24;
    localparam int TRANS_MAT = 22;
    localparam int TRANS_PLV = 20;
    localparam int TRANS_PPN = 0;

    localparam logic [5:0] PS_4K      = 6'd12;
    localparam logic [5:0] PS_4M      = 6'd22;
    localparam logic [1:0] MAT_CACHED = 2'd1;

    localparam fault_t FAULT_NONE    = 2'd0;
    localparam fault_t FAULT_REFILL  = 2'd1;
    localparam fault_t FAULT_INVALID = 2'd2;
    localparam fault_t FAULT_MODIFY  = 2'd3;

    localparam mgmt_op_t OP_WRITE      = 2'd0;
    localparam mgmt_op_t OP_SEARCH     = 2'd1;
    localparam mgmt_op_t OP_INVALIDATE = 2'd2;

    localparam inv_op_t INV_ALL         = 5'd0;
    localparam inv_op_t INV_ALL_ALT     = 5'd1;
    localparam inv_op_t INV_GLOBAL      = 5'd2;
    localparam inv_op_t INV_NON_GLOBAL  = 5'd3;
    localparam inv_op_t INV_ASID        = 5'd4;
    localparam inv_op_t INV_ASID_VA     = 5'd5;
    localparam inv_op_t INV_ASID_VA_ALT = 5'd6;

    function automatic logic tlb_match(input tlb_cmp_t cmp, input asid_t asid,
                                       input vppn_t vppn);
        logic asid_ok;
        logic vppn_ok;
        asid_ok = cmp[CMP_G] || (cmp[CMP_ASID +: $bits(asid_t)] == asid);
        // 4 MiB pages ignore the low 10 VPPN bits
        if (cmp[CMP_PS +: 6] == PS_4K) begin
            vppn_ok = cmp[CMP_VPPN +: $bits(vppn_t)] == vppn;
        end else if (cmp[CMP_PS +: 6] == PS_4M) begin
            vppn_ok = cmp[CMP_VPPN + 10 +: 9] == vppn[18:10];
        end else begin
            vppn_ok = 1'b0;
        end
        return cmp[CMP_E] && asid_ok && vppn_ok;
    endfunction

endpackage

`default_nettype wire

//--- hw/tlb_entry_array.sv
`default_nettype none

module tlb_entry_array import tlb_pkg::*; #(
    parameter int ENTRIES = 16,
    localparam int IDX_W = $clog2(ENTRIES)
) (
    input  logic             clk,
    input  logic             rstn,

    input  logic             mgmt_valid,
    input  mgmt_op_t         mgmt_op,
    input  logic [IDX_W-1:0] mgmt_index,
    input  tlb_cmp_t         wr_cmp,
    input  tlb_trans_t       wr_even,
    input  tlb_trans_t       wr_odd,
    input  inv_op_t          inv_op,
    input  asid_t            key_asid,
    input  vppn_t            key_vppn,

    output tlb_cmp_t         entry_cmp  [ENTRIES],
    output tlb_trans_t       entry_even [ENTRIES],
    output tlb_trans_t       entry_odd  [ENTRIES]
);

    logic [ENTRIES-1:0] inv_sel;
    logic               do_write;
    logic               do_inv;

    assign do_write = mgmt_valid && (mgmt_op == OP_WRITE);
    assign do_inv   = mgmt_valid && (mgmt_op == OP_INVALIDATE);

    // Per-entry invalidate select
    for (genvar i = 0; i < ENTRIES; i++) begin : g_sel
        logic glob;
        logic asid_eq;
        logic sel;

        assign glob    = entry_cmp[i][CMP_G];
        assign asid_eq = entry_cmp[i][CMP_ASID +: $bits(asid_t)] == key_asid;

        always_comb begin
            case (inv_op)
                INV_ALL, INV_ALL_ALT: begin
                    sel = 1'b1;
                end
                INV_GLOBAL: begin
                    sel = glob;
                end
                INV_NON_GLOBAL: begin
                    sel = !glob;
                end
                INV_ASID: begin
                    sel = !glob && asid_eq;
                end
                INV_ASID_VA, INV_ASID_VA_ALT: begin
                    // Non-global, so the match already requires equal ASID
                    sel = !glob && tlb_match(entry_cmp[i], key_asid, key_vppn);
                end
                default: begin
                    sel = 1'b0;
                end
            endcase
        end

        assign inv_sel[i] = sel;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                entry_cmp[i]  <= '0;
                entry_even[i] <= '0;
                entry_odd[i]  <= '0;
            end
        end else if (do_write) begin
            entry_cmp[mgmt_index]  <= wr_cmp;
            entry_even[mgmt_index] <= wr_even;
            entry_odd[mgmt_index]  <= wr_odd;
        end else if (do_inv) begin
            for (int i = 0; i < ENTRIES; i++) begin
                if (inv_sel[i]) begin
                    entry_cmp[i][CMP_E] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/tlb_lookup.sv
`default_nettype none

module tlb_lookup import tlb_pkg::*; #(
    parameter int ENTRIES = 16
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       flush,

    input  logic       in_valid,
    output logic       in_ready,
    input  vaddr_t     in_vaddr,
    input  logic       in_store,

    output logic       out_valid,
    input  logic       out_ready,
    output paddr_t     paddr,
    output logic       cached,
    output fault_t     fault,

    input  logic       pg,
    input  logic [1:0] crmd_datm,
    input  vaddr_t     dmw0,
    input  vaddr_t     dmw1,
    input  asid_t      cur_asid,

    input  tlb_cmp_t   entry_cmp  [ENTRIES],
    input  tlb_trans_t entry_even [ENTRIES],
    input  tlb_trans_t entry_odd  [ENTRIES]
);

    logic [ENTRIES-1:0] hit_vec;
    logic [5:0]         hit_ps;
    tlb_trans_t         hit_even;
    tlb_trans_t         hit_odd;

    logic               s1_valid;
    vaddr_t             s1_vaddr;
    logic               s1_store;
    logic               s1_hit;
    logic [5:0]         s1_ps;
    tlb_trans_t         s1_even;
    tlb_trans_t         s1_odd;

    logic               s1_adv;
    logic               s2_adv;
    logic               is_4k;
    tlb_trans_t         page;
    ppn_t               ppn;
    paddr_t             tlb_paddr;
    fault_t             tlb_fault;
    logic               dmw0_hit;
    logic               dmw1_hit;
    paddr_t             nxt_paddr;
    logic               nxt_cached;
    fault_t             nxt_fault;

    assign s2_adv   = !out_valid || out_ready;
    assign s1_adv   = !s1_valid || s2_adv;
    assign in_ready = s1_adv;

    for (genvar i = 0; i < ENTRIES; i++) begin : g_match
        assign hit_vec[i] = tlb_match(entry_cmp[i], cur_asid, in_vaddr[31:13]);
    end

    // At most one entry should hit, so OR-merge instead of a mux
    always_comb begin
        hit_ps   = '0;
        hit_even = '0;
        hit_odd  = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (hit_vec[i]) begin
                hit_ps   = hit_ps | entry_cmp[i][CMP_PS +: 6];
                hit_even = hit_even | entry_even[i];
                hit_odd  = hit_odd | entry_odd[i];
            end
        end
    end

    // Page select and fault priority
    assign is_4k     = s1_ps == PS_4K;
    assign page      = (is_4k ? s1_vaddr[12] : s1_vaddr[21]) ? s1_odd : s1_even;
    assign ppn       = page[TRANS_PPN +: $bits(ppn_t)];
    assign tlb_paddr = is_4k ? {ppn, s1_vaddr[11:0]} : {ppn[19:10], s1_vaddr[21:0]};
    assign tlb_fault = !s1_hit                      ? FAULT_REFILL  :
                       !page[TRANS_V]               ? FAULT_INVALID :
                       (s1_store && !page[TRANS_D]) ? FAULT_MODIFY  : FAULT_NONE;

    assign dmw0_hit = s1_vaddr[31:29] == dmw0[31:29];
    assign dmw1_hit = s1_vaddr[31:29] == dmw1[31:29];

    always_comb begin
        nxt_fault = FAULT_NONE;
        if (!pg) begin
            nxt_paddr  = s1_vaddr;
            nxt_cached = crmd_datm == 2'd1;
        end else if (dmw0_hit) begin
            nxt_paddr  = {dmw0[27:25], s1_vaddr[28:0]};
            nxt_cached = dmw0[4];
        end else if (dmw1_hit) begin
            nxt_paddr  = {dmw1[27:25], s1_vaddr[28:0]};
            nxt_cached = dmw1[4];
        end else begin
            nxt_fault  = tlb_fault;
            nxt_paddr  = (tlb_fault == FAULT_NONE) ? tlb_paddr : '0;
            nxt_cached = (tlb_fault == FAULT_NONE) && (page[TRANS_MAT +: 2] == MAT_CACHED);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (flush) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_valid <= in_valid;
            end
            if (s2_adv) begin
                out_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            s1_vaddr <= in_vaddr;
            s1_store <= in_store;
            s1_hit   <= |hit_vec;
            s1_ps    <= hit_ps;
            s1_even  <= hit_even;
            s1_odd   <= hit_odd;
        end
        // Response held until it transfers
        if (s2_adv && s1_valid) begin
            paddr  <= nxt_paddr;
            cached <= nxt_cached;
            fault  <= nxt_fault;
        end
    end

endmodule

`default_nettype wire

//--- hw/tlb_search.sv
`default_nettype none

module tlb_search import tlb_pkg::*; #(
    parameter int ENTRIES = 16,
    localparam int IDX_W = $clog2(ENTRIES)
) (
    input  logic             clk,
    input  logic             rstn,

    input  logic             mgmt_valid,
    input  mgmt_op_t         mgmt_op,
    input  asid_t            key_asid,
    input  vppn_t            key_vppn,
    input  tlb_cmp_t         entry_cmp [ENTRIES],

    output logic             srch_valid,
    output logic             srch_hit,
    output logic [IDX_W-1:0] srch_index
);

    logic [ENTRIES-1:0] match_vec;
    logic [IDX_W-1:0]   first_idx;
    logic               do_search;

    assign do_search = mgmt_valid && (mgmt_op == OP_SEARCH);

    for (genvar i = 0; i < ENTRIES; i++) begin : g_match
        assign match_vec[i] = tlb_match(entry_cmp[i], key_asid, key_vppn);
    end

    // Lowest index wins, zero on a miss
    always_comb begin
        first_idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                first_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            srch_valid <= 1'b0;
        end else begin
            srch_valid <= do_search;
        end
    end

    always_ff @(posedge clk) begin
        if (do_search) begin
            srch_hit   <= |match_vec;
            srch_index <= first_idx;
        end
    end

endmodule

`default_nettype wire

//--- hw/tlb_top.sv
`default_nettype none

module tlb_top import tlb_pkg::*; #(
    parameter int ENTRIES = 16,
    localparam int IDX_W = $clog2(ENTRIES)
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             flush,

    // Data-side translation
    input  logic             in_valid,
    output logic             in_ready,
    input  vaddr_t           in_vaddr,
    input  logic             in_store,
    output logic             out_valid,
    input  logic             out_ready,
    output paddr_t           paddr,
    output logic             cached,
    output fault_t           fault,

    // Mode inputs
    input  logic             pg,
    input  logic [1:0]       crmd_datm,
    input  vaddr_t           dmw0,
    input  vaddr_t           dmw1,
    input  asid_t            cur_asid,

    // Management
    input  logic             mgmt_valid,
    input  mgmt_op_t         mgmt_op,
    input  logic [IDX_W-1:0] mgmt_index,
    input  tlb_cmp_t         wr_cmp,
    input  tlb_trans_t       wr_even,
    input  tlb_trans_t       wr_odd,
    input  inv_op_t          inv_op,
    input  asid_t            key_asid,
    input  vppn_t            key_vppn,

    output logic             srch_valid,
    output logic             srch_hit,
    output logic [IDX_W-1:0] srch_index
);

    tlb_cmp_t   entry_cmp  [ENTRIES];
    tlb_trans_t entry_even [ENTRIES];
    tlb_trans_t entry_odd  [ENTRIES];

    tlb_entry_array #(
        .ENTRIES(ENTRIES)
    ) entry_array_i (
        .clk       (clk),
        .rstn      (rstn),
        .mgmt_valid(mgmt_valid),
        .mgmt_op   (mgmt_op),
        .mgmt_index(mgmt_index),
        .wr_cmp    (wr_cmp),
        .wr_even   (wr_even),
        .wr_odd    (wr_odd),
        .inv_op    (inv_op),
        .key_asid  (key_asid),
        .key_vppn  (key_vppn),
        .entry_cmp (entry_cmp),
        .entry_even(entry_even),
        .entry_odd (entry_odd)
    );

    tlb_lookup #(
        .ENTRIES(ENTRIES)
    ) lookup_i (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_vaddr  (in_vaddr),
        .in_store  (in_store),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .paddr     (paddr),
        .cached    (cached),
        .fault     (fault),
        .pg        (pg),
        .crmd_datm (crmd_datm),
        .dmw0      (dmw0),
        .dmw1      (dmw1),
        .cur_asid  (cur_asid),
        .entry_cmp (entry_cmp),
        .entry_even(entry_even),
        .entry_odd (entry_odd)
    );

    tlb_search #(
        .ENTRIES(ENTRIES)
    ) search_i (
        .clk       (clk),
        .rstn      (rstn),
        .mgmt_valid(mgmt_valid),
        .mgmt_op   (mgmt_op),
        .key_asid  (key_asid),
        .key_vppn  (key_vppn),
        .entry_cmp (entry_cmp),
        .srch_valid(srch_valid),
        .srch_hit  (srch_hit),
        .srch_index(srch_index)
    );

endmodule

`default_nettype wire

//--- verification/tlb_top_assert.sv
`default_nettype none

module tlb_top_assert import tlb_pkg::*; (
    input logic     clk,
    input logic     rstn,
    input logic     flush,
    input logic     out_valid,
    input logic     out_ready,
    input paddr_t   paddr,
    input logic     cached,
    input fault_t   fault,
    input logic     mgmt_valid,
    input mgmt_op_t mgmt_op,
    input logic     srch_valid
);

    // Stalled response must not move
    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready && !flush |=>
            out_valid && $stable(paddr) && $stable(cached) && $stable(fault))
        else $error("response changed while out_ready was low");

    a_srch_rise: assert property (@(posedge clk) disable iff (!rstn)
        mgmt_valid && mgmt_op == OP_SEARCH |=> srch_valid)
        else $error("srch_valid missing one cycle after a search");

    a_srch_only: assert property (@(posedge clk) disable iff (!rstn)
        srch_valid |-> $past(mgmt_valid && mgmt_op == OP_SEARCH))
        else $error("srch_valid without a search in the previous cycle");

    a_reset: assert property (@(posedge clk) !rstn |-> !out_valid && !srch_valid)
        else $error("valid output high during reset");

endmodule

bind tlb_top tlb_top_assert tlb_top_assert_i (
    .clk       (clk),
    .rstn      (rstn),
    .flush     (flush),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .paddr     (paddr),
    .cached    (cached),
    .fault     (fault),
    .mgmt_valid(mgmt_valid),
    .mgmt_op   (mgmt_op),
    .srch_valid(srch_valid)
);

`default_nettype wire

//--- verification/tlb_top_tb.sv
`default_nettype none

module tlb_top_tb import tlb_pkg::*;;

    localparam int ENTRIES = 16;
    localparam int IDX_W   = $clog2(ENTRIES);
    localparam int TIMEOUT = 200;

    logic             clk;
    logic             rstn;
    logic             flush;
    logic             in_valid;
    logic             in_ready;
    vaddr_t           in_vaddr;
    logic             in_store;
    logic             out_valid;
    logic             out_ready;
    paddr_t           paddr;
    logic             cached;
    fault_t           fault;
    logic             pg;
    logic [1:0]       crmd_datm;
    vaddr_t           dmw0;
    vaddr_t           dmw1;
    asid_t            cur_asid;
    logic             mgmt_valid;
    mgmt_op_t         mgmt_op;
    logic [IDX_W-1:0] mgmt_index;
    tlb_cmp_t         wr_cmp;
    tlb_trans_t       wr_even;
    tlb_trans_t       wr_odd;
    inv_op_t          inv_op;
    asid_t            key_asid;
    vppn_t            key_vppn;
    logic             srch_valid;
    logic             srch_hit;
    logic [IDX_W-1:0] srch_index;

    // Model of the entry table
    tlb_cmp_t   m_cmp  [ENTRIES];
    tlb_trans_t m_even [ENTRIES];
    tlb_trans_t m_odd  [ENTRIES];
    tlb_cmp_t   tbl_cmp  [4];
    tlb_trans_t tbl_even [4];
    tlb_trans_t tbl_odd  [4];

    logic [34:0] exp_q [$];
    int          cyc_q [$];
    int          stall_q [$];

    integer seed = 32'h647d;
    string  cur_test = "reset";
    int     tests;
    int     checks;
    int     errors;
    int     err_start;
    int     cycle_cnt;
    int     stall_cnt;
    logic   bp_mode;

    tlb_top #(
        .ENTRIES(ENTRIES)
    ) tlb_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic tlb_cmp_t make_cmp(input logic e, input asid_t a, input logic g,
                                          input logic [5:0] ps, input vppn_t v);
        return {e, a, g, ps, v};
    endfunction

    function automatic tlb_trans_t make_trans(input logic v, input logic d,
                                              input logic [1:0] mat, input ppn_t ppn);
        return {v, d, mat, 2'd0, ppn};
    endfunction

    function automatic logic model_match(input int i, input asid_t asid, input vppn_t vppn);
        tlb_cmp_t   c;
        logic [5:0] ps;
        c  = m_cmp[i];
        ps = c[CMP_PS +: 6];
        if (!c[CMP_E] || (!c[CMP_G] && c[CMP_ASID +: 10] != asid)) begin
            return 1'b0;
        end
        if (ps == PS_4K) begin
            return c[CMP_VPPN +: 19] == vppn;
        end else if (ps == PS_4M) begin
            return c[CMP_VPPN + 10 +: 9] == vppn[18:10];
        end
        return 1'b0;
    endfunction

    // Returns {paddr, cached, fault}
    function automatic logic [34:0] expected_translation(input vaddr_t va, input logic st);
        paddr_t     pa;
        logic       c;
        fault_t     f;
        int         hit_i;
        logic [5:0] ps;
        tlb_trans_t page;
        pa    = '0;
        c     = 1'b0;
        f     = FAULT_NONE;
        hit_i = -1;
        if (!pg) begin
            pa = va;
            c  = crmd_datm == 2'd1;
        end else if (va[31:29] == dmw0[31:29]) begin
            pa = {dmw0[27:25], va[28:0]};
            c  = dmw0[4];
        end else if (va[31:29] == dmw1[31:29]) begin
            pa = {dmw1[27:25], va[28:0]};
            c  = dmw1[4];
        end else begin
            for (int i = ENTRIES - 1; i >= 0; i--) begin
                if (model_match(i, cur_asid, va[31:13])) begin
                    hit_i = i;
                end
            end
            if (hit_i < 0) begin
                f = FAULT_REFILL;
            end else begin
                ps   = m_cmp[hit_i][CMP_PS +: 6];
                page = ((ps == PS_4K) ? va[12] : va[21]) ? m_odd[hit_i] : m_even[hit_i];
                if (!page[TRANS_V]) begin
                    f = FAULT_INVALID;
                end else if (st && !page[TRANS_D]) begin
                    f = FAULT_MODIFY;
                end else begin
                    pa = (ps == PS_4K) ? {page[19:0], va[11:0]} : {page[19:10], va[21:0]};
                    c  = page[TRANS_MAT +: 2] == MAT_CACHED;
                end
            end
        end
        return {pa, c, f};
    endfunction

    // Returns {hit, index} for the lowest matching entry
    function automatic logic [IDX_W:0] expected_search(input asid_t a, input vppn_t v);
        logic hit;
        int   idx;
        hit = 1'b0;
        idx = 0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (model_match(i, a, v)) begin
                hit = 1'b1;
                idx = i;
            end
        end
        return {hit, IDX_W'(idx)};
    endfunction

    task automatic check_paddr(input string name, input paddr_t exp, input paddr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_fault(input string name, input fault_t exp, input fault_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input logic [IDX_W-1:0] exp,
                               input logic [IDX_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // Compares every response transfer against the queued expectation
    always @(posedge clk) begin : compare_responses
        logic [34:0] want;
        int          acc_cycle;
        int          acc_stall;
        if (rstn) begin
            cycle_cnt++;
            if (!out_ready) begin
                stall_cnt++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: a response arrived with no request in flight", cur_test);
                end else begin
                    want      = exp_q.pop_front();
                    acc_cycle = cyc_q.pop_front();
                    acc_stall = stall_q.pop_front();
                    check_paddr({cur_test, " paddr"}, want[34:3], paddr);
                    check_bit({cur_test, " cached"}, want[2], cached);
                    check_fault({cur_test, " fault"}, want[1:0], fault);
                    if (acc_stall == stall_cnt && cycle_cnt - acc_cycle != 2) begin
                        errors++;
                        $display("[ERROR] %s latency expected 2 actual %0d", cur_test,
                                 cycle_cnt - acc_cycle);
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_translation(in_vaddr, in_store));
                cyc_q.push_back(cycle_cnt);
                stall_q.push_back(stall_cnt);
            end
        end
    end

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clk);
        if (bp_mode) begin
            rnd       = $random(seed);
            out_ready = rnd[0];
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s done, %0d errors", cur_test, errors - err_start);
    endtask

    task automatic send_req(input vaddr_t va, input logic st);
        int   n;
        logic accepted;
        n        = 0;
        accepted = 1'b0;
        in_valid = 1'b1;
        in_vaddr = va;
        in_store = st;
        while (!accepted && n < TIMEOUT) begin
            @(posedge clk);
            accepted = in_ready;
            next_cycle();
            n++;
        end
        in_valid = 1'b0;
        if (!accepted) begin
            $display("%s: timed out waiting for in_ready", cur_test);
            errors++;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: timed out waiting for responses to drain", cur_test);
            errors++;
        end
    endtask

    task automatic write_entry(input int idx, input tlb_cmp_t c, input tlb_trans_t e,
                               input tlb_trans_t o);
        mgmt_valid = 1'b1;
        mgmt_op    = OP_WRITE;
        mgmt_index = IDX_W'(idx);
        wr_cmp     = c;
        wr_even    = e;
        wr_odd     = o;
        @(posedge clk);
        next_cycle();
        m_cmp[idx]  = c;
        m_even[idx] = e;
        m_odd[idx]  = o;
        mgmt_valid = 1'b0;
    endtask

    task automatic write_table();
        for (int i = 0; i < ENTRIES; i++) begin
            if (i < 4) begin
                write_entry(i, tbl_cmp[i], tbl_even[i], tbl_odd[i]);
            end else begin
                write_entry(i, '0, '0, '0);
            end
        end
    endtask

    task automatic invalidate(input inv_op_t op, input asid_t a, input vppn_t v);
        logic g;
        logic sel;
        mgmt_valid = 1'b1;
        mgmt_op    = OP_INVALIDATE;
        inv_op     = op;
        key_asid   = a;
        key_vppn   = v;
        @(posedge clk);
        next_cycle();
        for (int i = 0; i < ENTRIES; i++) begin
            g = m_cmp[i][CMP_G];
            case (op)
                5'd0, 5'd1: sel = 1'b1;
                5'd2:       sel = g;
                5'd3:       sel = !g;
                5'd4:       sel = !g && m_cmp[i][CMP_ASID +: 10] == a;
                5'd5, 5'd6: sel = !g && model_match(i, a, v);
                default:    sel = 1'b0;
            endcase
            if (sel) begin
                m_cmp[i][CMP_E] = 1'b0;
            end
        end
        mgmt_valid = 1'b0;
    endtask

    task automatic search_check(input asid_t a, input vppn_t v);
        logic [IDX_W:0] want;
        want       = expected_search(a, v);
        mgmt_valid = 1'b1;
        mgmt_op    = OP_SEARCH;
        key_asid   = a;
        key_vppn   = v;
        @(posedge clk);
        next_cycle();
        mgmt_valid = 1'b0;
        check_bit({cur_test, " srch_valid"}, 1'b1, srch_valid);
        check_bit({cur_test, " srch_hit"}, want[IDX_W], srch_hit);
        check_index({cur_test, " srch_index"}, want[IDX_W-1:0], srch_index);
    endtask

    initial begin : stimulus
        logic [31:0] rnd;
        vaddr_t      va;
        rstn = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        in_vaddr = '0;
        in_store = 1'b0;
        out_ready = 1'b1;
        pg = 1'b0;
        crmd_datm = 2'd0;
        dmw0 = '0;
        dmw1 = '0;
        cur_asid = '0;
        mgmt_valid = 1'b0;
        mgmt_op = OP_WRITE;
        mgmt_index = '0;
        wr_cmp = '0;
        wr_even = '0;
        wr_odd = '0;
        inv_op = '0;
        key_asid = '0;
        key_vppn = '0;
        bp_mode = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            m_cmp[i]  = '0;
            m_even[i] = '0;
            m_odd[i]  = '0;
        end
        // 4K ASID 5, 4M global, 4K ASID 7, 4K ASID 5 next to entry 2
        tbl_cmp[0]  = make_cmp(1'b1, 10'd5, 1'b0, PS_4K, 19'h00010);
        tbl_even[0] = make_trans(1'b1, 1'b1, MAT_CACHED, 20'h12345);
        tbl_odd[0]  = make_trans(1'b1, 1'b0, 2'd0, 20'h0abcd);
        tbl_cmp[1]  = make_cmp(1'b1, 10'd0, 1'b1, PS_4M, 19'h00400);
        tbl_even[1] = make_trans(1'b1, 1'b1, MAT_CACHED, 20'h40000);
        tbl_odd[1]  = make_trans(1'b0, 1'b1, MAT_CACHED, 20'h80000);
        tbl_cmp[2]  = make_cmp(1'b1, 10'd7, 1'b0, PS_4K, 19'h00030);
        tbl_even[2] = make_trans(1'b1, 1'b1, 2'd2, 20'h00777);
        tbl_odd[2]  = make_trans(1'b1, 1'b1, MAT_CACHED, 20'h00888);
        tbl_cmp[3]  = make_cmp(1'b1, 10'd5, 1'b0, PS_4K, 19'h00031);
        tbl_even[3] = make_trans(1'b1, 1'b1, MAT_CACHED, 20'h00333);
        tbl_odd[3]  = make_trans(1'b0, 1'b0, 2'd0, 20'h00444);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        begin_test("reset");
        check_bit({cur_test, " in_ready"}, 1'b1, in_ready);
        check_bit({cur_test, " out_valid"}, 1'b0, out_valid);
        check_bit({cur_test, " srch_valid"}, 1'b0, srch_valid);
        end_test();

        begin_test("direct");
        for (int d = 0; d < 3; d++) begin
            crmd_datm = 2'(d);
            for (int k = 0; k < 3; k++) begin
                rnd = $random(seed);
                send_req(rnd, rnd[0]);
            end
            drain();
        end
        end_test();

        begin_test("windows");
        pg   = 1'b1;
        dmw0 = 32'ha400_0011;
        dmw1 = 32'h8200_0000;
        send_req(32'ha123_4567, 1'b0);
        send_req(32'h8765_4321, 1'b1);
        send_req(32'hbfff_fffc, 1'b0);
        drain();
        // Both windows cover the same segment
        dmw1 = 32'ha600_0000;
        send_req(32'ha000_1000, 1'b0);
        drain();
        end_test();

        begin_test("mapped");
        dmw0     = 32'he000_0000;
        dmw1     = 32'hc000_0000;
        cur_asid = 10'd5;
        write_table();
        send_req(32'h0002_0abc, 1'b0);
        send_req(32'h0002_1abc, 1'b0);
        send_req(32'h0002_1abc, 1'b1);
        send_req(32'h0002_0abc, 1'b1);
        send_req(32'h0080_1234, 1'b0);
        send_req(32'h00a0_0010, 1'b0);
        send_req(32'h0006_0010, 1'b0);
        send_req(32'h0006_2040, 1'b0);
        send_req(32'h1000_0000, 1'b0);
        drain();
        cur_asid = 10'd7;
        send_req(32'h0006_0010, 1'b0);
        send_req(32'h0006_1010, 1'b1);
        send_req(32'h0080_0008, 1'b1);
        drain();
        end_test();

        begin_test("backpressure");
        cur_asid = 10'd5;
        bp_mode  = 1'b1;
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            va  = {tbl_cmp[rnd[3:2]][CMP_VPPN +: 19], rnd[12:0]};
            if (rnd[5:4] == 2'd3) begin
                va = $random(seed);
            end
            send_req(va, rnd[6]);
            if (rnd[8]) begin
                next_cycle();
            end
        end
        drain();
        bp_mode   = 1'b0;
        out_ready = 1'b1;
        end_test();

        begin_test("search");
        write_entry(9, tbl_cmp[1], tbl_even[1], tbl_odd[1]);
        search_check(10'd5, 19'h00010);
        search_check(10'd3, 19'h00400);
        search_check(10'd5, 19'h00401);
        search_check(10'd6, 19'h00030);
        search_check(10'd5, 19'h00050);
        end_test();

        begin_test("invalidate");
        for (int op = 0; op < 7; op++) begin
            write_table();
            invalidate(inv_op_t'(op), 10'd5, 19'h00010);
            for (int i = 0; i < 4; i++) begin
                search_check(tbl_cmp[i][CMP_ASID +: 10], tbl_cmp[i][CMP_VPPN +: 19]);
                cur_asid = tbl_cmp[i][CMP_ASID +: 10];
                send_req({tbl_cmp[i][CMP_VPPN +: 19], 13'h0010}, 1'b0);
            end
            drain();
        end
        end_test();

        finish_run();
    end

endmodule

`default_nettype wire

//--- tlb_top.f
hw/tlb_pkg.sv
hw/tlb_entry_array.sv
hw/tlb_lookup.sv
hw/tlb_search.sv
hw/tlb_top.sv
verification/tlb_top_assert.sv
verification/tlb_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tlb_top_tb
RTL_TOP   ?= tlb_top
FILELIST  ?= tlb_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RTL_SRCS  ?= hw/tlb_pkg.sv hw/tlb_entry_array.sv hw/tlb_lookup.sv hw/tlb_search.sv hw/tlb_top.sv
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
